/* logic/core_pkg.sv */
// shared widths, opcodes and instruction views for the rv32i core
// word-only loads and stores, no compressed or system encodings
// unsupported opcodes are replaced by nop_instr in the decoder
package core_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_idx_t;

  ////////////////////////////////////////
  // major opcodes
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;

  localparam logic [2:0] f3_word    = 3'b010;     // lw / sw width code

  // arithmetic first, then the six branch compares
  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_sltu, alu_sll,
    alu_srl, alu_sra, alu_eq, alu_ne, alu_lt, alu_ge, alu_ltu, alu_geu
  } alu_op_t;

  ////////////////////////////////////////
  // instruction formats, msb first
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_type_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_type_t;

  typedef struct packed {
    logic [19:0] imm;       // upper 20 bits of the result
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } u_type_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } j_type_t;

  // one word, six views
  typedef union packed {
    r_type_t r;
    i_type_t i;
    s_type_t s;
    b_type_t b;
    u_type_t u;
    j_type_t j;
  } instr_u;

  localparam instr_u nop_instr = 32'h0000_0013;   // addi x0, x0, 0

endpackage

/* logic/fetch_if.sv */
// fetched instruction and its pc, fetch stage to decode/execute
// valid/ready handshake, data held stable until the transfer
`timescale 1ns/100ps

interface fetch_if;
  import core_pkg::*;

  logic   valid;    // buffer holds an instruction
  logic   ready;    // decode/execute can take it
  instr_u instr;
  word_t  pc;

  modport fetch (
    output valid, instr, pc,
    input  ready
  );

  modport decode (
    input  valid, instr, pc,
    output ready
  );

endinterface

/* logic/lsu_if.sv */
// memory request from decode/execute to the load/store unit
// req and its fields stay up until done, done is a single-cycle pulse
// rdata only meaningful on done of a load
`timescale 1ns/100ps

interface lsu_if;
  import core_pkg::*;

  logic  req;
  logic  we;       // 1 = store
  word_t addr;
  word_t wdata;
  logic  done;
  word_t rdata;

  modport core (
    output req, we, addr, wdata,
    input  done, rdata
  );

  modport lsu (
    input  req, we, addr, wdata,
    output done, rdata
  );

endinterface

/* logic/if_stage.sv */
// fetch stage, one outstanding fetch and a one-entry buffer
// a redirect clears the buffer, a fetch already on the bus is dropped
// no new request while the buffer is full
// pc resets to boot_addr_i, which must be stable around reset
`timescale 1ns/100ps

module if_stage (
  input  logic            clk,
  input  logic            rst_n,
  input  core_pkg::word_t boot_addr_i,
  input  logic            fetch_enable_i,
  input  logic            pc_set_i,        // redirect from decode/execute
  input  core_pkg::word_t pc_target_i,
  output logic            instr_req_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  output core_pkg::word_t instr_addr_o,
  input  core_pkg::word_t instr_rdata_i,
  fetch_if.fetch          fetch,
  output logic            busy_o
);
  import core_pkg::*;

  logic   req_q;            // request on the bus
  logic   out_q;            // granted, waiting for rvalid
  logic   drop_q;           // pending response belongs to a stale path
  logic   buf_valid_q;
  word_t  pc_q;             // address of the next fetch
  word_t  addr_q;           // address of the fetch in flight
  word_t  pc_next;
  word_t  buf_pc_q;
  instr_u buf_instr_q;
  logic   gnt;
  logic   accept;
  logic   fire;
  logic   inflight_next;
  logic   buf_valid_next;
  logic   start;

  ////////////////////////////////////////
  // handshake bookkeeping
  assign gnt    = req_q & instr_gnt_i;
  assign accept = out_q & instr_rvalid_i & ~drop_q & ~pc_set_i;  // response kept
  assign fire   = buf_valid_q & fetch.ready;

  assign inflight_next  = req_q | (out_q & ~instr_rvalid_i);
  assign buf_valid_next = ~pc_set_i & (accept | (buf_valid_q & ~fire));

  // new fetch only with nothing in flight and an empty buffer
  assign start = fetch_enable_i & ~inflight_next & ~buf_valid_next;

  assign pc_next = pc_set_i ? pc_target_i : (accept ? addr_q + 32'd4 : pc_q);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      req_q       <= 1'b0;
      out_q       <= 1'b0;
      drop_q      <= 1'b0;
      buf_valid_q <= 1'b0;
      pc_q        <= boot_addr_i;
    end
    else
    begin
      req_q       <= req_q ? ~instr_gnt_i : start;   // hold until granted
      out_q       <= gnt | (out_q & ~instr_rvalid_i);
      drop_q      <= inflight_next & (drop_q | pc_set_i);
      buf_valid_q <= buf_valid_next;
      pc_q        <= pc_next;
    end
  end

  ////////////////////////////////////////
  // address and buffer payload
  always_ff @(posedge clk)
  begin
    if (start)
      addr_q <= pc_next;    // redirect target already folded in
    if (accept)
    begin
      buf_instr_q <= instr_rdata_i;
      buf_pc_q    <= addr_q;
    end
  end

  assign instr_req_o  = req_q;
  assign instr_addr_o = addr_q;

  assign fetch.valid = buf_valid_q;
  assign fetch.instr = buf_valid_q ? buf_instr_q : nop_instr;  // nop while empty
  assign fetch.pc    = buf_pc_q;

  assign busy_o = req_q | out_q | buf_valid_q;

endmodule

/* logic/register_file.sv */
// 31 general registers, x0 reads as zero and ignores writes
// combinational reads, write at the clock edge
`timescale 1ns/100ps

module register_file (
  input  logic               clk,
  input  logic               rst_n,
  input  core_pkg::reg_idx_t raddr_a_i,
  input  core_pkg::reg_idx_t raddr_b_i,
  input  core_pkg::reg_idx_t waddr_i,
  input  logic               we_i,
  input  core_pkg::word_t    wdata_i,
  output core_pkg::word_t    rdata_a_o,
  output core_pkg::word_t    rdata_b_o
);
  import core_pkg::*;

  word_t regs_q [1:31];     // no storage for x0

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int k = 1; k < 32; k++)
        regs_q[k] <= '0;
    end
    else if (we_i && waddr_i != '0)
      regs_q[waddr_i] <= wdata_i;
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* logic/alu.sv */
// integer alu, purely combinational
// shifts use operand_b_i[4:0] only
// compare ops drive cond_o, result_o then carries the same bit
`timescale 1ns/100ps

module alu (
  input  core_pkg::alu_op_t operator_i,
  input  core_pkg::word_t   operand_a_i,
  input  core_pkg::word_t   operand_b_i,
  output core_pkg::word_t   result_o,
  output logic              cond_o
);
  import core_pkg::*;

  logic       lt_s;
  logic       lt_u;
  logic       eq;
  logic [4:0] shamt;

  assign lt_s  = $signed(operand_a_i) < $signed(operand_b_i);
  assign lt_u  = operand_a_i < operand_b_i;
  assign eq    = operand_a_i == operand_b_i;
  assign shamt = operand_b_i[4:0];

  // branch condition
  always_comb
  begin
    case (operator_i)
      alu_eq:  cond_o = eq;
      alu_ne:  cond_o = ~eq;
      alu_lt:  cond_o = lt_s;
      alu_ge:  cond_o = ~lt_s;
      alu_ltu: cond_o = lt_u;
      alu_geu: cond_o = ~lt_u;
      default: cond_o = 1'b0;
    endcase
  end

  always_comb
  begin
    case (operator_i)
      alu_add:  result_o = operand_a_i + operand_b_i;   // also address and jalr target
      alu_sub:  result_o = operand_a_i - operand_b_i;
      alu_and:  result_o = operand_a_i & operand_b_i;
      alu_or:   result_o = operand_a_i | operand_b_i;
      alu_xor:  result_o = operand_a_i ^ operand_b_i;
      alu_slt:  result_o = {{(xlen-1){1'b0}}, lt_s};
      alu_sltu: result_o = {{(xlen-1){1'b0}}, lt_u};
      alu_sll:  result_o = operand_a_i << shamt;
      alu_srl:  result_o = operand_a_i >> shamt;
      alu_sra:  result_o = $signed(operand_a_i) >>> shamt;
      default:  result_o = {{(xlen-1){1'b0}}, cond_o};
    endcase
  end

endmodule

/* logic/id_ex_stage.sv */
// decode and execute in one cycle for alu ops, branches and jumps
// loads and stores hold ready low until the unit reports done
// a load writes rd in its done cycle, so a following use reads it directly
// unsupported opcodes and non-word memory accesses run as nop
`timescale 1ns/100ps

module id_ex_stage (
  input  logic            clk,
  input  logic            rst_n,
  fetch_if.decode         fetch,
  lsu_if.core             mem,
  output logic            pc_set_o,
  output core_pkg::word_t pc_target_o
);
  import core_pkg::*;

  instr_u   iw;             // word as decoded
  logic     legal;
  logic     fire;           // instruction accepted this cycle
  alu_op_t  alu_op;
  logic     a_pc;
  logic     a_zero;
  logic     b_imm;
  word_t    imm;
  word_t    imm_i;
  word_t    imm_s;
  word_t    imm_b;
  word_t    imm_u;
  word_t    imm_j;
  logic     rf_we_dec;
  logic     link;           // rd gets pc + 4
  logic     is_branch;
  logic     is_jal;
  logic     is_jalr;
  logic     is_mem;
  word_t    rs1_data;
  word_t    rs2_data;
  word_t    op_a;
  word_t    op_b;
  word_t    alu_result;
  logic     alu_cond;
  logic     rf_we;
  reg_idx_t rf_waddr;
  word_t    rf_wdata;
  logic     mem_busy_q;     // access open, stage stalled
  logic     mem_we_q;
  reg_idx_t mem_rd_q;
  word_t    mem_addr_q;
  word_t    mem_wdata_q;

  // funct3 to alu op, alt picks sub / sra
  function automatic alu_op_t arith_op(input logic [2:0] funct3, input logic alt);
    case (funct3)
      3'b000:  return alt ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return alt ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  function automatic alu_op_t cmp_op(input logic [2:0] funct3);
    case (funct3)
      3'b000:  return alu_eq;
      3'b001:  return alu_ne;
      3'b100:  return alu_lt;
      3'b101:  return alu_ge;
      3'b110:  return alu_ltu;
      default: return alu_geu;
    endcase
  endfunction

  ////////////////////////////////////////
  // decode
  always_comb
  begin
    case (fetch.instr.r.opcode)
      opc_op, opc_op_imm, opc_lui, opc_auipc, opc_jal, opc_jalr: legal = 1'b1;
      opc_branch:          legal = fetch.instr.b.funct3[2:1] != 2'b01;
      opc_load, opc_store: legal = fetch.instr.i.funct3 == f3_word;
      default:             legal = 1'b0;
    endcase
  end

  assign iw = legal ? fetch.instr : nop_instr;

  assign imm_i = {{20{iw.i.imm[11]}}, iw.i.imm};
  assign imm_s = {{20{iw.s.imm_hi[6]}}, iw.s.imm_hi, iw.s.imm_lo};
  assign imm_b = {{19{iw.b.imm_12}}, iw.b.imm_12, iw.b.imm_11, iw.b.imm_10_5,
                  iw.b.imm_4_1, 1'b0};
  assign imm_u = {iw.u.imm, 12'b0};
  assign imm_j = {{11{iw.j.imm_20}}, iw.j.imm_20, iw.j.imm_19_12, iw.j.imm_11,
                  iw.j.imm_10_1, 1'b0};

  always_comb
  begin
    alu_op    = alu_add;
    a_pc      = 1'b0;
    a_zero    = 1'b0;
    b_imm     = 1'b1;
    imm       = imm_i;
    rf_we_dec = 1'b0;
    link      = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    is_mem    = 1'b0;
    case (iw.r.opcode)
      opc_op:
      begin
        alu_op    = arith_op(iw.r.funct3, iw.r.funct7[5]);
        b_imm     = 1'b0;
        rf_we_dec = 1'b1;
      end
      opc_op_imm:
      begin
        // bit 30 only selects srai, addi has no sub form
        alu_op    = arith_op(iw.i.funct3, iw.i.funct3 == 3'b101 && iw.r.funct7[5]);
        rf_we_dec = 1'b1;
      end
      opc_lui:
      begin
        a_zero    = 1'b1;
        imm       = imm_u;
        rf_we_dec = 1'b1;
      end
      opc_auipc:
      begin
        a_pc      = 1'b1;
        imm       = imm_u;
        rf_we_dec = 1'b1;
      end
      opc_jal:
      begin
        imm       = imm_j;
        is_jal    = 1'b1;
        link      = 1'b1;
        rf_we_dec = 1'b1;
      end
      opc_jalr:
      begin
        is_jalr   = 1'b1;
        link      = 1'b1;
        rf_we_dec = 1'b1;
      end
      opc_branch:
      begin
        alu_op    = cmp_op(iw.b.funct3);
        b_imm     = 1'b0;
        imm       = imm_b;
        is_branch = 1'b1;
      end
      opc_load:  is_mem = 1'b1;   // rs1 + imm_i
      opc_store:
      begin
        imm    = imm_s;
        is_mem = 1'b1;
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////
  // execute
  register_file i_register_file (
    .clk       ( clk       ),
    .rst_n     ( rst_n     ),
    .raddr_a_i ( iw.r.rs1  ),
    .raddr_b_i ( iw.r.rs2  ),
    .waddr_i   ( rf_waddr  ),
    .we_i      ( rf_we     ),
    .wdata_i   ( rf_wdata  ),
    .rdata_a_o ( rs1_data  ),
    .rdata_b_o ( rs2_data  )
  );

  assign op_a = a_zero ? '0 : (a_pc ? fetch.pc : rs1_data);
  assign op_b = b_imm ? imm : rs2_data;

  alu i_alu (
    .operator_i  ( alu_op     ),
    .operand_a_i ( op_a       ),
    .operand_b_i ( op_b       ),
    .result_o    ( alu_result ),
    .cond_o      ( alu_cond   )
  );

  assign fetch.ready = ~mem_busy_q;
  assign fire        = fetch.valid & ~mem_busy_q;

  assign pc_set_o    = fire & (is_jal | is_jalr | (is_branch & alu_cond));
  assign pc_target_o = is_jalr ? {alu_result[xlen-1:1], 1'b0} : fetch.pc + imm;

  // load data has the port while stalled
  assign rf_we    = (fire & rf_we_dec) | (mem.done & mem_busy_q & ~mem_we_q);
  assign rf_waddr = mem_busy_q ? mem_rd_q : iw.r.rd;
  assign rf_wdata = mem_busy_q ? mem.rdata : (link ? fetch.pc + 32'd4 : alu_result);

  ////////////////////////////////////////
  // open memory access
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      mem_busy_q <= 1'b0;
    else if (fire && is_mem)
      mem_busy_q <= 1'b1;
    else if (mem.done)
      mem_busy_q <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (fire && is_mem)
    begin
      mem_we_q    <= iw.r.opcode == opc_store;
      mem_addr_q  <= alu_result;
      mem_wdata_q <= rs2_data;
      mem_rd_q    <= iw.r.rd;
    end
  end

  assign mem.req   = mem_busy_q;
  assign mem.we    = mem_we_q;
  assign mem.addr  = mem_addr_q;
  assign mem.wdata = mem_wdata_q;

endmodule

/* logic/load_store_unit.sv */
// word loads and stores over the req/gnt/rvalid data port
// one access at a time, a store also completes on rvalid
// done follows data_rvalid_i directly
`timescale 1ns/100ps

module load_store_unit (
  input  logic            clk,
  input  logic            rst_n,
  lsu_if.lsu              mem,
  output logic            data_req_o,
  input  logic            data_gnt_i,
  input  logic            data_rvalid_i,
  output logic            data_we_o,
  output core_pkg::word_t data_addr_o,
  output core_pkg::word_t data_wdata_o,
  input  core_pkg::word_t data_rdata_i,
  output logic            busy_o
);
  import core_pkg::*;

  enum logic [1:0] {st_idle, st_req, st_wait} state_q, state_d;

  logic  we_q;
  word_t addr_q;
  word_t wdata_q;

  ////////////////////////////////////////
  // access FSM
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      st_idle: if (mem.req)       state_d = st_req;    // new request seen
      st_req:  if (data_gnt_i)    state_d = st_wait;
      st_wait: if (data_rvalid_i) state_d = st_idle;
      default:                    state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= st_idle;
    else
      state_q <= state_d;
  end

  // request copy, held on the bus until granted
  always_ff @(posedge clk)
  begin
    if (state_q == st_idle && mem.req)
    begin
      we_q    <= mem.we;
      addr_q  <= mem.addr;
      wdata_q <= mem.wdata;
    end
  end

  assign data_req_o   = state_q == st_req;
  assign data_we_o    = we_q;
  assign data_addr_o  = addr_q;
  assign data_wdata_o = wdata_q;

  assign mem.done  = data_rvalid_i;
  assign mem.rdata = data_rdata_i;

  // includes the cycle the request is only seen
  assign busy_o = (state_q != st_idle) | mem.req;

endmodule

/* logic/rv32_core.sv */
// rv32i core top, fetch + decode/execute + load/store unit
// instruction and data ports use req/gnt/rvalid, one access outstanding each
// word accesses only, no byte enables
// fetch starts after reset once fetch_enable_i is high
`timescale 1ns/100ps

module rv32_core (
  input  logic            clk,
  input  logic            rst_n,
  input  core_pkg::word_t boot_addr_i,
  input  logic            fetch_enable_i,

  // instruction memory
  output logic            instr_req_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  output core_pkg::word_t instr_addr_o,
  input  core_pkg::word_t instr_rdata_i,

  // data memory
  output logic            data_req_o,
  input  logic            data_gnt_i,
  input  logic            data_rvalid_i,
  output logic            data_we_o,
  output core_pkg::word_t data_addr_o,
  output core_pkg::word_t data_wdata_o,
  input  core_pkg::word_t data_rdata_i,

  output logic            core_busy_o
);
  import core_pkg::*;

  logic  pc_set;        // redirect, decode/execute to fetch
  word_t pc_target;
  logic  if_busy;
  logic  lsu_busy;

  fetch_if i_fetch_if ();
  lsu_if   i_lsu_if ();

  ////////////////////////////////////////
  // stages
  if_stage i_if_stage (
    .clk            ( clk            ),
    .rst_n          ( rst_n          ),
    .boot_addr_i    ( boot_addr_i    ),
    .fetch_enable_i ( fetch_enable_i ),
    .pc_set_i       ( pc_set         ),
    .pc_target_i    ( pc_target      ),
    .instr_req_o    ( instr_req_o    ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .fetch          ( i_fetch_if     ),
    .busy_o         ( if_busy        )
  );

  id_ex_stage i_id_ex_stage (
    .clk         ( clk        ),
    .rst_n       ( rst_n      ),
    .fetch       ( i_fetch_if ),
    .mem         ( i_lsu_if   ),
    .pc_set_o    ( pc_set     ),
    .pc_target_o ( pc_target  )
  );

  load_store_unit i_load_store_unit (
    .clk           ( clk           ),
    .rst_n         ( rst_n         ),
    .mem           ( i_lsu_if      ),
    .data_req_o    ( data_req_o    ),
    .data_gnt_i    ( data_gnt_i    ),
    .data_rvalid_i ( data_rvalid_i ),
    .data_we_o     ( data_we_o     ),
    .data_addr_o   ( data_addr_o   ),
    .data_wdata_o  ( data_wdata_o  ),
    .data_rdata_i  ( data_rdata_i  ),
    .busy_o        ( lsu_busy      )
  );

  assign core_busy_o = if_busy | lsu_busy;

endmodule

/* tb/tb_rv32_core.sv */
// testbench for rv32_core, program and expected stores come from tb/core_patterns.mem
// pattern word 0 holds {program length, store count}, then the program, then addr/data pairs
// program is loaded at address 0 and boot_addr_i is tied to 0
// both memories add random grant and rvalid delays of 0..3 cycles
// data memory covers the low 1 KiB only, higher address bits are ignored
`timescale 1ns/100ps

module tb_rv32_core;
  import core_pkg::*;

  localparam int pat_words   = 256;
  localparam int mem_words   = 256;
  localparam int tail_cycles = 40;    // quiet time after the last store
  localparam int word_bytes  = xlen / 8;

  logic  clk;
  logic  rst_n;
  word_t boot_addr;
  logic  fetch_enable;
  logic  instr_req;
  logic  instr_gnt;
  logic  instr_rvalid;
  word_t instr_addr;
  word_t instr_rdata;
  logic  data_req;
  logic  data_gnt;
  logic  data_rvalid;
  logic  data_we;
  word_t data_addr;
  word_t data_wdata;
  word_t data_rdata;
  logic  core_busy;

  word_t  patterns [0:pat_words-1];
  instr_u imem [0:mem_words-1];
  word_t  dmem [0:mem_words-1];

  integer seed = 70651;
  int     prog_len;
  int     store_cnt;
  int     store_idx;          // stores seen so far
  int     cycles;
  int     cycle_limit;

  // memory model state
  logic  first_fetch_seen;
  logic  i_pend;              // fetch granted, response pending
  int    i_gwait;
  int    i_rwait;
  word_t i_addr;
  logic  d_pend;
  int    d_gwait;
  int    d_rwait;
  word_t d_value;             // load data captured at grant

  rv32_core i_rv32_core (
    .clk            ( clk          ),
    .rst_n          ( rst_n        ),
    .boot_addr_i    ( boot_addr    ),
    .fetch_enable_i ( fetch_enable ),
    .instr_req_o    ( instr_req    ),
    .instr_gnt_i    ( instr_gnt    ),
    .instr_rvalid_i ( instr_rvalid ),
    .instr_addr_o   ( instr_addr   ),
    .instr_rdata_i  ( instr_rdata  ),
    .data_req_o     ( data_req     ),
    .data_gnt_i     ( data_gnt     ),
    .data_rvalid_i  ( data_rvalid  ),
    .data_we_o      ( data_we      ),
    .data_addr_o    ( data_addr    ),
    .data_wdata_o   ( data_wdata   ),
    .data_rdata_i   ( data_rdata   ),
    .core_busy_o    ( core_busy    )
  );

  ////////////////////////////////////////
  // helpers and compare tasks
  function automatic int rand_delay();
    return int'($unsigned($random(seed)) % 4);   // 0..3 cycles
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_fetch_addr(input word_t addr);
    if (addr !== boot_addr)
      stop_with_failure($sformatf("ERR %0t: first fetch from %h, expected boot address %h",
                                  $time, addr, boot_addr));
  endtask

  task automatic check_store(input word_t addr, input word_t data);
    word_t exp_addr;
    word_t exp_data;
    if (store_idx >= store_cnt)
      stop_with_failure($sformatf("store to %h seen after all %0d expected stores",
                                  addr, store_cnt));
    exp_addr = patterns[1 + prog_len + 2*store_idx];
    exp_data = patterns[2 + prog_len + 2*store_idx];
    if (addr !== exp_addr || data !== exp_data)
      stop_with_failure($sformatf("ERR %0t: store %0d wrote %h to %h, expected %h to %h",
                                  $time, store_idx, data, addr, exp_data, exp_addr));
  endtask

  task automatic check_busy(input logic busy, input logic exp);
    if (busy !== exp)
      stop_with_failure($sformatf("ERR %0t: core busy is %b, expected %b",
                                  $time, busy, exp));
  endtask

  ////////////////////////////////////////
  // clock and main sequence
  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial
  begin
    rst_n        = 1'b0;
    boot_addr    = '0;
    fetch_enable = 1'b1;
    instr_gnt    = 1'b0;
    instr_rvalid = 1'b0;
    instr_rdata  = '0;
    data_gnt     = 1'b0;
    data_rvalid  = 1'b0;
    data_rdata   = '0;
    store_idx    = 0;
    cycles       = 0;
    $readmemh("tb/core_patterns.mem", patterns);
    if ($isunknown(patterns[0]))
      stop_with_failure("pattern file tb/core_patterns.mem missing or empty");
    prog_len    = int'(patterns[0][31:16]);
    store_cnt   = int'(patterns[0][15:0]);
    cycle_limit = 40 * (prog_len + store_cnt) + 10 + tail_cycles;
    for (int k = 0; k < mem_words; k++)
    begin
      imem[k] = nop_instr;
      dmem[k] = word_t'(k * word_bytes) ^ 32'h5ac3_0000;   // address-tagged fill
    end
    for (int k = 0; k < prog_len; k++)
      imem[k] = patterns[1 + k];

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    if (instr_req !== 1'b0 || data_req !== 1'b0)
      stop_with_failure("memory request high in the first cycle after reset");
    check_busy(core_busy, 1'b0);           // nothing fetched or open yet

    wait (store_idx == store_cnt);
    repeat (tail_cycles) @(posedge clk);   // extra stores trip check_store
    $display("TEST OK");
    $finish;
  end

  // watchdog
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit)
      stop_with_failure($sformatf("timeout after %0d cycles with %0d of %0d stores seen",
                                  cycles, store_idx, store_cnt));
  end

  // busy covers every request on the bus and every pending response
  always @(posedge clk)
  begin
    if (rst_n && (instr_req || data_req || i_pend || d_pend))
      check_busy(core_busy, 1'b1);
  end

  ////////////////////////////////////////
  // instruction memory
  always @(posedge clk)
  begin
    instr_gnt    <= 1'b0;
    instr_rvalid <= 1'b0;
    if (!rst_n)
    begin
      first_fetch_seen <= 1'b0;
      i_pend           <= 1'b0;
      i_gwait          <= rand_delay();
      if (instr_req !== 1'b0 || data_req !== 1'b0)
        stop_with_failure("memory request high while reset was active");
    end
    else
    begin
      if (instr_req && !first_fetch_seen)
      begin
        check_fetch_addr(instr_addr);
        first_fetch_seen <= 1'b1;
      end
      if (instr_req && instr_gnt)           // handshake done at this edge
      begin
        i_addr  <= instr_addr;
        i_pend  <= 1'b1;
        i_rwait <= rand_delay();
      end
      else if (instr_req)
      begin
        if (i_gwait == 0)
        begin
          instr_gnt <= 1'b1;
          i_gwait   <= rand_delay();
        end
        else
          i_gwait <= i_gwait - 1;
      end
      if (i_pend)
      begin
        if (i_rwait == 0)
        begin
          instr_rvalid <= 1'b1;
          instr_rdata  <= imem[i_addr[9:2]];
          i_pend       <= 1'b0;
        end
        else
          i_rwait <= i_rwait - 1;
      end
    end
  end

  ////////////////////////////////////////
  // data memory, stores checked at grant
  always @(posedge clk)
  begin
    data_gnt    <= 1'b0;
    data_rvalid <= 1'b0;
    if (!rst_n)
    begin
      d_pend  <= 1'b0;
      d_gwait <= rand_delay();
    end
    else
    begin
      if (data_req && data_gnt)
      begin
        if (data_we)
        begin
          check_store(data_addr, data_wdata);
          dmem[data_addr[9:2]] <= data_wdata;
          store_idx <= store_idx + 1;
        end
        d_value <= dmem[data_addr[9:2]];
        d_pend  <= 1'b1;
        d_rwait <= rand_delay();
      end
      else if (data_req)
      begin
        if (d_gwait == 0)
        begin
          data_gnt <= 1'b1;
          d_gwait  <= rand_delay();
        end
        else
          d_gwait <= d_gwait - 1;
      end
      if (d_pend)
      begin
        if (d_rwait == 0)
        begin
          data_rvalid <= 1'b1;
          data_rdata  <= d_value;
          d_pend      <= 1'b0;
        end
        else
          d_rwait <= d_rwait - 1;
      end
    end
  end

endmodule

/* tb/core_patterns.mem */
// word 0: {program length, store count}, then one instruction per line from address 0
// then one expected store per line: address data
004F0018
10000093 // addi x1, x0, 0x100
FF900113 // addi x2, x0, -7
00500193 // addi x3, x0, 5
00310233 // add  x4, x2, x3
0040A023 // sw   x4, 0(x1)
402182B3 // sub  x5, x3, x2
0050A223 // sw   x5, 4(x1)
40315333 // sra  x6, x2, x3
0060A423 // sw   x6, 8(x1)
003153B3 // srl  x7, x2, x3
0070A623 // sw   x7, 12(x1)
00312433 // slt  x8, x2, x3
0080A823 // sw   x8, 16(x1)
003134B3 // sltu x9, x2, x3
0090AA23 // sw   x9, 20(x1)
003176B3 // and  x13, x2, x3
00D0AC23 // sw   x13, 24(x1)
00316733 // or   x14, x2, x3
00E0AE23 // sw   x14, 28(x1)
003147B3 // xor  x15, x2, x3
02F0A023 // sw   x15, 32(x1)
00311833 // sll  x16, x2, x3
0300A223 // sw   x16, 36(x1)
0F014513 // xori x10, x2, 0x0f0
02A0A423 // sw   x10, 40(x1)
40115593 // srai x11, x2, 1
02B0A623 // sw   x11, 44(x1)
FFF1B613 // sltiu x12, x3, -1
02C0A823 // sw   x12, 48(x1)
7F017893 // andi x17, x2, 0x7f0
0310AA23 // sw   x17, 52(x1)
F001E913 // ori  x18, x3, -256
0320AC23 // sw   x18, 56(x1)
FFA12993 // slti x19, x2, -6
0330AE23 // sw   x19, 60(x1)
01C19A13 // slli x20, x3, 28
0540A023 // sw   x20, 64(x1)
01C15A93 // srli x21, x2, 28
0550A223 // sw   x21, 68(x1)
ABCDEB37 // lui  x22, 0xabcde
0560A423 // sw   x22, 72(x1)
00001B97 // auipc x23, 1 at pc 0xa4
0570A623 // sw   x23, 76(x1)
0000AC03 // lw   x24, 0(x1)
003C0C13 // addi x24, x24, 3 right after the load
0580A823 // sw   x24, 80(x1)
00318463 // beq  x3, x3, +8 taken
100D0D13 // addi x26, x26, 0x100 marker
00310463 // beq  x2, x3, +8 not taken
001D0D13 // addi x26, x26, 1
00311463 // bne  x2, x3 taken
100D0D13 // marker
00319463 // bne  x3, x3 not taken
001D0D13 // count
00314463 // blt  x2, x3 taken
100D0D13 // marker
0021C463 // blt  x3, x2 not taken
001D0D13 // count
0021D463 // bge  x3, x2 taken
100D0D13 // marker
00315463 // bge  x2, x3 not taken
001D0D13 // count
0021E463 // bltu x3, x2 taken
100D0D13 // marker
00316463 // bltu x2, x3 not taken
001D0D13 // count
00317463 // bgeu x2, x3 taken
100D0D13 // marker
0021F463 // bgeu x3, x2 not taken
001D0D13 // count
00800DEF // jal  x27, +8 at pc 0x118
100D0D13 // marker
00000E97 // auipc x29, 0 at pc 0x120
00DE8E67 // jalr x28, 13(x29), lands on 0x12c
100D0D13 // marker
05A0AA23 // sw   x26, 84(x1)
05B0AC23 // sw   x27, 88(x1)
05C0AE23 // sw   x28, 92(x1)
0000006F // jal  x0, 0 spin
00000100 FFFFFFFE // add
00000104 0000000C // sub
00000108 FFFFFFFF // sra
0000010C 07FFFFFF // srl
00000110 00000001 // slt
00000114 00000000 // sltu
00000118 00000001 // and
0000011C FFFFFFFD // or
00000120 FFFFFFFC // xor
00000124 FFFFFF20 // sll
00000128 FFFFFF09 // xori
0000012C FFFFFFFC // srai
00000130 00000001 // sltiu
00000134 000007F0 // andi
00000138 FFFFFF05 // ori
0000013C 00000001 // slti
00000140 50000000 // slli
00000144 0000000F // srli
00000148 ABCDE000 // lui
0000014C 000010A4 // auipc
00000150 00000001 // reload and add
00000154 00000006 // branch count, no marker
00000158 0000011C // jal link
0000015C 00000128 // jalr link

/* all.f */
logic/core_pkg.sv
logic/fetch_if.sv
logic/lsu_if.sv
logic/if_stage.sv
logic/register_file.sv
logic/alu.sv
logic/id_ex_stage.sv
logic/load_store_unit.sv
logic/rv32_core.sv
tb/tb_rv32_core.sv

/* Makefile */
TOP := tb_rv32_core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f all.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^TEST OK$$"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir
